/* Makefile */
SIM      = verilator
TOP      = tb_clocking
FILELIST = verilog.f
OBJ_DIR  = obj_dir
LOG      = sim.log
FLAGS    = --binary --timing --assert --timescale 1ns/1ns -Wno-fatal -j 0

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Result comes from the log, a missing result line also counts as failure
run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -F -q '** FAIL **' $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	elif ! grep -F -q '** PASS **' $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* hdl/cfg_pkg.sv */
package cfg_pkg;

    // Operation on the configuration strobes, one per core_clk
    typedef enum logic [1:0] {
        CFG_NOP   = 2'b00,
        CFG_WRITE = 2'b01,
        CFG_READ  = 2'b10
    } cfg_op_e;

    // Register map
    typedef enum logic [1:0] {
        ADDR_CLK_SRC    = 2'd0,   // Bit 0 source
        ADDR_DIV_CORE   = 2'd1,   // Bits 2:0 core divider
        ADDR_DIV_USER   = 2'd2,   // Bits 2:0 user divider
        ADDR_SOFT_RESET = 2'd3    // Bit 0 reset request
    } cfg_addr_e;

endpackage

/* hdl/clk_pkg.sv */
`include "clocking_consts.svh"

package clk_pkg;

    // Where the core and user clocks come from
    typedef enum logic {
        CLK_SRC_PLL = 1'b0,   // Divided PLL clocks
        CLK_SRC_EXT = 1'b1    // Pad clock, boot default
    } clk_src_e;

    // Divider ratio, 0 and 1 pass the clock through
    // 2 to 7 divide by that value
    typedef logic [`CLK_DIV_WIDTH-1:0] div_ratio_t;

endpackage

/* hdl/clock_cfg_regs.sv */
`timescale 1ns/1ns
`include "clocking_consts.svh"

module clock_cfg_regs import cfg_pkg::*, clk_pkg::*; (
    input  logic                       core_clk,
    input  logic                       resetb,       // Raw reset, not the staged one
    input  cfg_op_e                    cfg_op,       // Sampled every rising core_clk
    input  cfg_addr_e                  cfg_addr,
    input  logic [`CFG_DATA_WIDTH-1:0] cfg_wdata,
    output logic [`CFG_DATA_WIDTH-1:0] cfg_rdata,    // Valid with cfg_rvalid only
    output logic                       cfg_rvalid,   // One cycle per read
    output clk_src_e                   ext_clk_sel,
    output div_ratio_t                 sel,
    output div_ratio_t                 sel2,
    output logic                       ext_reset
);

    clk_src_e                   clk_src_q;
    div_ratio_t                 div_core_q;
    div_ratio_t                 div_user_q;
    logic                       soft_reset_q;
    logic                       wr_en;
    logic                       rd_en;
    logic [`CFG_DATA_WIDTH-1:0] rdata_next;

    assign wr_en = (cfg_op == CFG_WRITE);
    assign rd_en = (cfg_op == CFG_READ);

    // Register writes
    // Boot on the pad clock with pass-through dividers
    always_ff @(posedge core_clk or negedge resetb) begin
        if (!resetb) begin
            clk_src_q    <= CLK_SRC_EXT;
            div_core_q   <= div_ratio_t'(1);
            div_user_q   <= div_ratio_t'(1);
            soft_reset_q <= 1'b0;
        end else if (wr_en) begin
            case (cfg_addr)
                ADDR_CLK_SRC:    clk_src_q    <= clk_src_e'(cfg_wdata[0]);
                ADDR_DIV_CORE:   div_core_q   <= cfg_wdata[`CLK_DIV_WIDTH-1:0];
                ADDR_DIV_USER:   div_user_q   <= cfg_wdata[`CLK_DIV_WIDTH-1:0];
                ADDR_SOFT_RESET: soft_reset_q <= cfg_wdata[0];
                default:         ;
            endcase
        end
    end

    // Readback mux, upper bits zero
    always_comb begin
        rdata_next = '0;
        case (cfg_addr)
            ADDR_CLK_SRC:    rdata_next[0] = clk_src_q;
            ADDR_DIV_CORE:   rdata_next[`CLK_DIV_WIDTH-1:0] = div_core_q;
            ADDR_DIV_USER:   rdata_next[`CLK_DIV_WIDTH-1:0] = div_user_q;
            ADDR_SOFT_RESET: rdata_next[0] = soft_reset_q;
            default:         rdata_next = '0;
        endcase
    end

    // Valid pulse follows each read by one cycle
    always_ff @(posedge core_clk or negedge resetb) begin
        if (!resetb) begin
            cfg_rvalid <= 1'b0;
        end else begin
            cfg_rvalid <= rd_en;
        end
    end

    // Read data captured with the pulse
    always_ff @(posedge core_clk) begin
        if (rd_en) begin
            cfg_rdata <= rdata_next;   // Held until the next read
        end
    end

    // Straight to the clocking block
    assign ext_clk_sel = clk_src_q;
    assign sel         = div_core_q;
    assign sel2        = div_user_q;
    assign ext_reset   = soft_reset_q;   // Pulls resetb_sync low downstream

    // No unsolicited read data
    property p_rvalid_after_read;
        @(posedge core_clk) disable iff (!resetb)
            cfg_rvalid |-> ($past(cfg_op) == CFG_READ);
    endproperty

    a_rvalid_after_read: assert property (p_rvalid_after_read)
        else $error("clock_cfg_regs: cfg_rvalid without a preceding read");

endmodule

/* hdl/clock_div.sv */
`timescale 1ns/1ns

module clock_div import clk_pkg::*; (
    input  logic       in_clk,    // Clock to divide
    input  logic       resetb,    // Async reset, active low
    input  div_ratio_t n,         // Requested ratio, may change at any time
    output logic       out_clk    // Divided or passed-through clock
);

    div_ratio_t n_lat;     // Ratio in force for the current period
    div_ratio_t count;     // Rising edges since the last wrap
    div_ratio_t half;      // Rising-edge high phase length
    logic       bypass;    // Ratio 0 or 1
    logic       wrap;      // Last edge of the period
    logic       out_pos;   // Output from the rising-edge counter
    logic       out_neg;   // Same, half a period later
    logic       out_div;

    assign bypass = (n_lat <= div_ratio_t'(1));
    assign half   = n_lat >> 1;   // Floor, the odd half cycle comes from out_neg

    // In bypass every edge counts as a wrap so a new n is picked up at once
    assign wrap = bypass || (count == n_lat - div_ratio_t'(1));

    // Counter and high phase
    // n is only taken at a wrap, so a period in progress always completes
    always_ff @(posedge in_clk or negedge resetb) begin
        if (!resetb) begin
            n_lat   <= '0;
            count   <= '0;
            out_pos <= 1'b0;
        end else if (wrap) begin
            n_lat   <= n;          // Resample the select
            count   <= '0;
            out_pos <= 1'b1;       // Start of a new period
        end else begin
            count <= count + div_ratio_t'(1);
            if (count == half - div_ratio_t'(1)) begin
                out_pos <= 1'b0;   // End of high phase
            end
        end
    end

    // Falling-edge copy of the high phase
    always_ff @(negedge in_clk or negedge resetb) begin
        if (!resetb) begin
            out_neg <= 1'b0;
        end else begin
            out_neg <= out_pos;
        end
    end

    // Odd ratios
    // OR with the delayed copy adds the missing half cycle of high time
    assign out_div = n_lat[0] ? (out_pos | out_neg) : out_pos;

    assign out_clk = bypass ? in_clk : out_div;

    // Counter stays inside the latched period, also across ratio changes
    property p_count_below_n;
        @(posedge in_clk) disable iff (!resetb)
            !bypass |-> (count < n_lat);
    endproperty

    a_count_below_n: assert property (p_count_below_n)
        else $error("clock_div: count %0d reached n %0d", count, n_lat);

endmodule

/* hdl/clocking_consts.svh */
`ifndef CLOCKING_CONSTS_SVH
`define CLOCKING_CONSTS_SVH

// Divider select width, ratios up to 7
`define CLK_DIV_WIDTH 3

// Core clock edges between resetb rising and resetb_sync rising
`define RESET_STAGES 3

// Configuration bus data width
`define CFG_DATA_WIDTH 8

`endif

/* hdl/clocking_top.sv */
`timescale 1ns/1ns
`include "clocking_consts.svh"

module clocking_top import cfg_pkg::*, clk_pkg::*; (
    input  logic                       resetb,       // Raw reset, active low
    input  logic                       ext_clk,      // Pad clock
    input  logic                       pll_clk,
    input  logic                       pll_clk90,
    input  cfg_op_e                    cfg_op,
    input  cfg_addr_e                  cfg_addr,
    input  logic [`CFG_DATA_WIDTH-1:0] cfg_wdata,
    output logic                       core_clk,
    output logic                       user_clk,
    output logic                       resetb_sync,
    output logic [`CFG_DATA_WIDTH-1:0] cfg_rdata,
    output logic                       cfg_rvalid
);

    clk_src_e   ext_clk_sel;   // Register block to clocking
    div_ratio_t sel;
    div_ratio_t sel2;
    logic       ext_reset;

    // Registers run on the clock they select
    clock_cfg_regs u_cfg_regs (
        .core_clk    (core_clk),
        .resetb      (resetb),
        .cfg_op      (cfg_op),
        .cfg_addr    (cfg_addr),
        .cfg_wdata   (cfg_wdata),
        .cfg_rdata   (cfg_rdata),
        .cfg_rvalid  (cfg_rvalid),
        .ext_clk_sel (ext_clk_sel),
        .sel         (sel),
        .sel2        (sel2),
        .ext_reset   (ext_reset)
    );

    core_clocking u_core_clocking (
        .resetb      (resetb),
        .ext_clk_sel (ext_clk_sel),
        .ext_clk     (ext_clk),
        .pll_clk     (pll_clk),
        .pll_clk90   (pll_clk90),
        .sel         (sel),
        .sel2        (sel2),
        .ext_reset   (ext_reset),
        .core_clk    (core_clk),
        .user_clk    (user_clk),
        .resetb_sync (resetb_sync)
    );

endmodule

/* hdl/core_clocking.sv */
`timescale 1ns/1ns
`include "clocking_consts.svh"

module core_clocking import clk_pkg::*; (
    input  logic       resetb,       // Raw reset, active low
    input  clk_src_e   ext_clk_sel,  // Source select from the register block
    input  logic       ext_clk,      // Pad clock
    input  logic       pll_clk,      // PLL clock
    input  logic       pll_clk90,    // PLL clock, 90 degree phase
    input  div_ratio_t sel,          // Core divider
    input  div_ratio_t sel2,         // User divider
    input  logic       ext_reset,    // Soft reset, active high
    output logic       core_clk,
    output logic       user_clk,
    output logic       resetb_sync   // Staged reset, active low
);

    logic                     pll_clk_sel;
    logic                     use_pll_first;     // First select stage
    logic                     use_pll_second;    // Second select stage, drives the muxes
    logic                     ext_clk_syncd_pre;
    logic                     ext_clk_syncd;     // ext_clk retimed to pll_clk
    logic                     core_ext_clk;
    logic                     pll_clk_divided;
    logic                     pll_clk90_divided;
    logic [`RESET_STAGES-1:0] reset_delay;

    assign pll_clk_sel = (ext_clk_sel == CLK_SRC_PLL);

    // Select chain and ext_clk synchronizer, both in the pll_clk domain
    // No check that the PLL is actually running
    always_ff @(posedge pll_clk or negedge resetb) begin
        if (!resetb) begin
            use_pll_first     <= 1'b0;
            use_pll_second    <= 1'b0;
            ext_clk_syncd_pre <= 1'b0;
            ext_clk_syncd     <= 1'b0;
        end else begin
            use_pll_first     <= pll_clk_sel;
            use_pll_second    <= use_pll_first;
            ext_clk_syncd_pre <= ext_clk;
            ext_clk_syncd     <= ext_clk_syncd_pre;   // Second flop for metastability
        end
    end

    // Core divider
    clock_div u_div_core (
        .in_clk  (pll_clk),
        .resetb  (resetb),
        .n       (sel),
        .out_clk (pll_clk_divided)
    );

    // User divider on the quadrature phase
    clock_div u_div_user (
        .in_clk  (pll_clk90),
        .resetb  (resetb),
        .n       (sel2),
        .out_clk (pll_clk90_divided)
    );

    // While the select moves, the pad clock is taken through its pll_clk copy
    // so both sides of the final mux are aligned to pll_clk
    assign core_ext_clk = use_pll_first ? ext_clk_syncd : ext_clk;

    assign core_clk = use_pll_second ? pll_clk_divided   : core_ext_clk;
    assign user_clk = use_pll_second ? pll_clk90_divided : core_ext_clk;

    // Reset delay chain, all ones in reset, zeros shifted in from the top
    always_ff @(posedge core_clk or negedge resetb) begin
        if (!resetb) begin
            reset_delay <= '1;
        end else begin
            reset_delay <= {1'b0, reset_delay[`RESET_STAGES-1:1]};
        end
    end

    // Soft reset acts directly, the chain is not restarted by it
    assign resetb_sync = ~(reset_delay[0] | ext_reset);

    // Once drained, the delay chain stays empty until the next raw reset
    property p_chain_not_retriggered;
        @(posedge core_clk) disable iff (!resetb)
            ($past(reset_delay) == '0) |-> (reset_delay == '0);
    endproperty

    a_chain_not_retriggered: assert property (p_chain_not_retriggered)
        else $error("core_clocking: reset delay chain restarted without raw reset");

endmodule

/* verification/tb_clocking.sv */
`timescale 1ns/1ns
`include "clocking_consts.svh"

module tb_clocking import cfg_pkg::*, clk_pkg::*; ();

    localparam int PLL_PERIOD_NS   = 10;
    localparam int EXT_PERIOD_NS   = 100;
    localparam int SETTLE_NS       = (7 + 8) * PLL_PERIOD_NS;  // Longest ratio plus 8 PLL periods
    localparam int TEST_CYCLES_EST = 160;                      // ext_clk cycles for all six tests
    localparam int MAX_CYCLES      = 25 * TEST_CYCLES_EST;

    logic                       resetb;
    logic                       ext_clk;
    logic                       pll_clk;
    logic                       pll_clk90;
    cfg_op_e                    cfg_op;
    cfg_addr_e                  cfg_addr;
    logic [`CFG_DATA_WIDTH-1:0] cfg_wdata;
    logic                       core_clk;
    logic                       user_clk;
    logic                       resetb_sync;
    logic [`CFG_DATA_WIDTH-1:0] cfg_rdata;
    logic                       cfg_rvalid;

    logic [`CFG_DATA_WIDTH-1:0] shadow [4];              // Expected register contents
    logic [31:0]                lfsr_state = 32'h9198;
    time                        core_rise;
    time                        user_rise;
    int                         core_period;
    int                         core_high;
    int                         user_period;
    int                         user_high;
    int                         errors;
    int                         checks;
    int                         tests_run;
    int                         errors_before;
    int                         cycle_count;

    clocking_top u_dut (
        .resetb      (resetb),
        .ext_clk     (ext_clk),
        .pll_clk     (pll_clk),
        .pll_clk90   (pll_clk90),
        .cfg_op      (cfg_op),
        .cfg_addr    (cfg_addr),
        .cfg_wdata   (cfg_wdata),
        .core_clk    (core_clk),
        .user_clk    (user_clk),
        .resetb_sync (resetb_sync),
        .cfg_rdata   (cfg_rdata),
        .cfg_rvalid  (cfg_rvalid)
    );

    // Pad clock
    initial begin
        ext_clk = 1'b0;
        forever #(EXT_PERIOD_NS / 2) ext_clk = ~ext_clk;
    end

    initial begin
        pll_clk = 1'b0;
        forever #(PLL_PERIOD_NS / 2) pll_clk = ~pll_clk;
    end

    // Quadrature phase, quarter period rounded to the 1 ns step
    initial begin
        pll_clk90 = 1'b0;
        #3;
        forever #(PLL_PERIOD_NS / 2) pll_clk90 = ~pll_clk90;
    end

    // Period and high time stamps
    always @(posedge core_clk) begin
        core_period = int'($time - core_rise);
        core_rise   = $time;
    end

    always @(negedge core_clk) begin
        core_high = int'($time - core_rise);
    end

    always @(posedge user_clk) begin
        user_period = int'($time - user_rise);
        user_rise   = $time;
    end

    always @(negedge user_clk) begin
        user_high = int'($time - user_rise);
    end

    // Run limit
    always @(posedge ext_clk) begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout after %0d ext_clk cycles, tests did not complete", cycle_count);
            $display("** FAIL **");
            $finish;
        end
    end

    // Galois form, one output bit per step
    function automatic logic step_lfsr();
        logic out_bit;
        out_bit    = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out_bit) begin
            lfsr_state = lfsr_state ^ 32'h8020_0003;   // Taps 32 22 2 1
        end
        return out_bit;
    endfunction

    function automatic logic [7:0] random_bits(input int count);
        logic [7:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            value = {value[6:0], step_lfsr()};
        end
        return value;
    endfunction

    // 0 and 1 pass the PLL clock, 2 to 7 divide
    function automatic int divided_period(input div_ratio_t ratio);
        return (ratio <= 1) ? PLL_PERIOD_NS : int'(ratio) * PLL_PERIOD_NS;
    endfunction

    // Implemented bits per register
    function automatic logic [7:0] reg_mask(input cfg_addr_e addr);
        return (addr == ADDR_DIV_CORE || addr == ADDR_DIV_USER) ? 8'h07 : 8'h01;
    endfunction

    task automatic report_mismatch(input string name, input int expected, input int actual);
        $display("** Error @ %0t ns: %s expected %0d, got %0d", $time, name, expected, actual);
    endtask

    task automatic check_value(input string name, input int expected, input int actual);
        checks++;
        assert (actual == expected) else begin
            errors++;
            report_mismatch(name, expected, actual);
        end
    endtask

    task automatic check_near(input string name, input int expected, input int actual,
                              input int tol);
        checks++;
        assert (actual >= expected - tol && actual <= expected + tol) else begin
            errors++;
            report_mismatch(name, expected, actual);
        end
    endtask

    // One full period and one high phase of each output
    task automatic check_clocks(input int exp_core, input int exp_user);
        repeat (2) @(posedge core_clk);
        #1;
        check_value("core_clk period", exp_core, core_period);
        @(negedge core_clk);
        #1;
        check_near("core_clk high time", exp_core / 2, core_high, 1);
        repeat (2) @(posedge user_clk);
        #1;
        check_value("user_clk period", exp_user, user_period);
        @(negedge user_clk);
        #1;
        check_near("user_clk high time", exp_user / 2, user_high, 1);
    endtask

    task automatic write_reg(input cfg_addr_e addr, input logic [7:0] data);
        @(posedge core_clk);
        #1;
        cfg_op    = CFG_WRITE;
        cfg_addr  = addr;
        cfg_wdata = data;
        @(posedge core_clk);                       // Register takes the value here
        #1;
        cfg_op       = CFG_NOP;
        shadow[addr] = data & reg_mask(addr);      // Unused bits read back as zero
    endtask

    task automatic read_reg(input cfg_addr_e addr);
        @(posedge core_clk);
        #1;
        cfg_op   = CFG_READ;
        cfg_addr = addr;
        @(posedge core_clk);
        #1;
        cfg_op = CFG_NOP;
        check_value("cfg_rvalid", 1, cfg_rvalid);
        check_value("cfg_rdata", shadow[addr], cfg_rdata);
        @(posedge core_clk);                       // Pulse is one cycle wide
        #1;
        check_value("cfg_rvalid", 0, cfg_rvalid);
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        $display("Test %0d %s done, %0d failed checks", tests_run, name, errors - errors_before);
        errors_before = errors;
    endtask

    // Staged reset stays low under the raw reset
    a_reset_holds: assert property (@(posedge ext_clk) !resetb |-> !resetb_sync)
        else begin
            errors++;
            report_mismatch("resetb_sync", 0, $sampled(resetb_sync));
        end

    // Valid pulse exactly one cycle after each read
    a_rvalid_follows_read: assert property (@(posedge core_clk) disable iff (!resetb)
            cfg_rvalid == ($past(cfg_op) == CFG_READ))
        else begin
            errors++;
            report_mismatch("cfg_rvalid", int'($past(cfg_op) == CFG_READ), $sampled(cfg_rvalid));
        end

    // Soft reset bit set means core held in reset
    a_soft_reset_low: assert property (@(posedge core_clk) disable iff (!resetb)
            shadow[ADDR_SOFT_RESET][0] |-> !resetb_sync)
        else begin
            errors++;
            report_mismatch("resetb_sync", 0, $sampled(resetb_sync));
        end

    initial begin
        logic [7:0] core_byte;
        logic [7:0] user_byte;
        logic [7:0] filler;

        resetb    = 1'b1;
        cfg_op    = CFG_NOP;
        cfg_addr  = ADDR_CLK_SRC;
        cfg_wdata = '0;
        shadow[ADDR_CLK_SRC]    = 8'h01;    // Boot on the pad clock
        shadow[ADDR_DIV_CORE]   = 8'h01;
        shadow[ADDR_DIV_USER]   = 8'h01;
        shadow[ADDR_SOFT_RESET] = 8'h00;
        #1;
        resetb = 1'b0;                      // Falling edge fires the async reset

        // Test 1, reset release on the third core_clk edge
        repeat (10) begin
            @(posedge core_clk);
            #1;
            check_value("resetb_sync", 0, resetb_sync);
        end
        resetb = 1'b1;
        for (int edge_n = 1; edge_n <= 3; edge_n++) begin
            @(posedge core_clk);
            #1;
            check_value("resetb_sync", (edge_n == 3) ? 1 : 0, resetb_sync);
        end
        finish_test("reset release");

        // Test 2, pad clock on both outputs, reset values read back
        check_clocks(EXT_PERIOD_NS, EXT_PERIOD_NS);
        for (int a = 0; a < 4; a++) begin
            read_reg(cfg_addr_e'(a));
        end
        finish_test("external mode");

        // Test 3, PLL source with random divider pairs
        filler = random_bits(7);
        write_reg(ADDR_CLK_SRC, {filler[6:0], 1'b0});
        read_reg(ADDR_CLK_SRC);
        repeat (8) begin
            core_byte = random_bits(8);
            user_byte = random_bits(8);
            write_reg(ADDR_DIV_CORE, core_byte);
            write_reg(ADDR_DIV_USER, user_byte);
            #(SETTLE_NS);                   // New ratio in force by now
            check_clocks(divided_period(core_byte[2:0]), divided_period(user_byte[2:0]));
            read_reg(ADDR_DIV_CORE);
            read_reg(ADDR_DIV_USER);
        end
        finish_test("PLL division");

        // Test 4, random data with upper bits set, source kept on the PLL
        filler = random_bits(7);
        write_reg(ADDR_CLK_SRC, {filler[6:0], 1'b0});
        write_reg(ADDR_DIV_CORE, random_bits(8));
        write_reg(ADDR_DIV_USER, random_bits(8));
        filler = random_bits(7);
        write_reg(ADDR_SOFT_RESET, {filler[6:0], 1'b0});
        for (int a = 0; a < 4; a++) begin
            read_reg(cfg_addr_e'(a));
        end
        finish_test("readback");

        // Test 5, soft reset acts in the write cycle and is released at once
        check_value("resetb_sync", 1, resetb_sync);
        write_reg(ADDR_SOFT_RESET, 8'h01);
        check_value("resetb_sync", 0, resetb_sync);
        repeat (3) @(posedge core_clk);
        #1;
        check_value("resetb_sync", 0, resetb_sync);
        read_reg(ADDR_SOFT_RESET);
        write_reg(ADDR_SOFT_RESET, 8'h00);
        check_value("resetb_sync", 1, resetb_sync);   // No new delay chain run
        finish_test("soft reset");

        // Test 6, back to the pad clock
        filler = random_bits(7);
        write_reg(ADDR_CLK_SRC, {filler[6:0], 1'b1});
        #(SETTLE_NS);
        check_clocks(EXT_PERIOD_NS, EXT_PERIOD_NS);
        read_reg(ADDR_CLK_SRC);
        finish_test("switch back");

        $display("Tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* verilog.f */
+incdir+hdl
hdl/clk_pkg.sv
hdl/cfg_pkg.sv
hdl/clock_div.sv
hdl/core_clocking.sv
hdl/clock_cfg_regs.sv
hdl/clocking_top.sv
verification/tb_clocking.sv
